// ==== hw/cen_gen.sv ====
/* DMA step enable divider */
`timescale 1ns/10ps
`include "prot_defs.svh"
`default_nettype none

module cen_gen (
    input  wire  clk,
    input  wire  rst,
    output logic cen_dma
);

    localparam int CW = $clog2(`PROT_CEN_DIV);

    logic [CW-1:0] cnt;

    // one pulse per wrap of the counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            cen_dma <= 1'b0;
        end else begin
            cen_dma <= 1'b0;
            if (cnt == CW'(`PROT_CEN_DIV - 1)) begin
                cnt     <= '0;
                cen_dma <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/obj_ram.sv ====
/* object RAM, 8K words with byte writes
   and a registered read */
`timescale 1ns/10ps
`default_nettype none

module obj_ram (
    input  wire                 clk,
    input  wire                 cs,
    input  wire          [13:1] addr,
    input  wire          [ 1:0] we,
    input  wire          [15:0] wdata,
    output prot_pkg::obj_word_u rdata
);

    localparam int WORDS = 8192;

    logic [15:0] mem [0:WORDS-1];

    always_ff @(posedge clk) begin
        if (cs) begin
            // low byte
            if (we[0])
                mem[addr][7:0] <= wdata[7:0];
            // high byte
            if (we[1])
                mem[addr][15:8] <= wdata[15:8];
            // old data on a write cycle
            rdata.raw <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/prio_dma.sv ====
/* object priority DMA: bus request handshake, four-step sweep
   and object RAM port mux with pin scramble */
`timescale 1ns/10ps
`include "prot_defs.svh"
`default_nettype none

module prio_dma (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen_dma,
    input  wire                 prot_cs,
    input  wire                 cpu_we,
    input  wire                 obj_cs,
    input  wire          [13:1] addr,
    input  wire          [ 1:0] dsn,
    input  wire          [15:0] din,
    output logic                bus_req,
    input  wire                 bus_grant,
    output logic                bus_ack,
    output logic                oram_cs,
    output logic         [13:1] oram_addr,
    output logic         [15:0] oram_wdata,
    output logic         [ 1:0] oram_we,
    input  wire prot_pkg::obj_word_u oram_rdata
);

    logic        trig;
    logic [13:1] dma_addr;
    logic [ 7:0] hw_prio;    // next hardware priority to write
    logic [ 7:0] level;      // current one-hot logical priority
    logic [ 6:0] entry;
    logic [ 1:0] st;
    logic        owr;

    // address order at the object chip pins
    function automatic logic [13:1] scramble(input logic [13:1] a);
        return {a[6:5], a[1], a[13:7], a[4:2]};
    endfunction

    assign trig = prot_cs && cpu_we && (addr[7:1] == `PROT_TRIG_OFS);

    // DMA owns the port while bus_ack is high
    assign oram_cs    = bus_ack ? 1'b1 : obj_cs;
    assign oram_addr  = bus_ack ? dma_addr : scramble(addr);
    assign oram_wdata = bus_ack ? {2{hw_prio}} : din;
    // low byte only during the sweep
    assign oram_we    = bus_ack ? {1'b0, owr} : (~dsn & {2{cpu_we & obj_cs}});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_req  <= 1'b0;
            bus_ack  <= 1'b0;
            dma_addr <= '0;
            hw_prio  <= '0;
            level    <= '0;
            entry    <= '0;
            st       <= '0;
            owr      <= 1'b0;
        end else begin
            // trigger restarts the sweep state
            if (trig) begin
                bus_req <= 1'b1;
                level   <= 8'd1;
                hw_prio <= 8'd1;
                entry   <= '0;
                st      <= '0;
            end
            // grant seen, take the bus
            if (bus_grant && bus_req) begin
                bus_req <= 1'b0;
                bus_ack <= 1'b1;
            end
            if (bus_ack && cen_dma) begin
                st <= st + 2'd1;
                case (st)
                    2'd0: begin
                        // fetch attribute word
                        dma_addr <= scramble({entry, 6'd3});
                        owr      <= 1'b0;
                    end
                    2'd2: begin
                        if (oram_rdata.fld.prio == level) begin
                            dma_addr <= {3'd0, entry, 3'd0};
                            owr      <= 1'b1;
                        end
                    end
                    2'd3: begin
                        owr   <= 1'b0;
                        entry <= entry + 7'd1;
                        if (owr)
                            hw_prio <= hw_prio + 8'd1;
                        // last entry of this level
                        if (&entry) begin
                            level <= level << 1;
                            if (level[7])
                                bus_ack <= 1'b0;
                        end
                    end
                    // step 1 waits for read data
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/prot_defs.svh ====
/* mailbox word addresses and command codes,
   DMA trigger offset and step enable divide */
`ifndef PROT_DEFS_SVH
`define PROT_DEFS_SVH

// snooped shared RAM word addresses
`define PROT_ADDR_DATA 13'hd05
`define PROT_ADDR_CMD  13'hc7e
`define PROT_ADDR_V0   13'hc0c
`define PROT_ADDR_V1   13'he58
`define PROT_ADDR_V2   13'h064

// command codes seen in the command register
`define PROT_CMD_ID     16'h100b
`define PROT_CMD_LOW4   16'h6003
`define PROT_CMD_LOW5   16'h6004
`define PROT_CMD_BIT0   16'h6000
`define PROT_CMD_BYTE_A 16'h0000
`define PROT_CMD_BYTE_B 16'h6007
`define PROT_CMD_CALC   16'h8abc

// addr[7:1] of a protection write that starts DMA
`define PROT_TRIG_OFS 7'd1
// clocks per DMA step, object chip runs slower
`define PROT_CEN_DIV 4

`endif

// ==== hw/prot_mailbox.sv ====
/* protection mailbox: snooped command, data and position registers,
   position calculation and registered answer mux */
`timescale 1ns/10ps
`include "prot_defs.svh"
`default_nettype none

module prot_mailbox (
    input  wire         clk,
    input  wire         rst,
    input  wire         ram_we,
    input  wire  [13:1] addr,
    input  wire  [ 1:0] dsn,
    input  wire  [15:0] din,
    output logic [15:0] dout
);

    import prot_pkg::*;

    logic [15:0] cmd;
    logic [15:0] data;
    logic [15:0] v0;
    logic [15:0] v1;
    logic [15:0] v2;
    // calculation terms
    logic [15:0] x;
    logic [15:0] x_neg;
    logic [15:0] hi;
    logic [15:0] s;
    logic [15:0] carry;
    logic [15:0] calc_nxt;
    logic [15:0] calc;

    // byte-wise merge, dsn is active low
    function automatic logic [15:0] merge_bytes(input logic [15:0] old,
                                                input logic [15:0] wr,
                                                input logic [1:0]  strobe_n);
        logic [15:0] res;
        res = old;
        if (!strobe_n[0])
            res[7:0] = wr[7:0];
        if (!strobe_n[1])
            res[15:8] = wr[15:8];
        return res;
    endfunction

    // snoop CPU writes into shared work RAM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd  <= '0;
            data <= '0;
            v0   <= '0;
            v1   <= '0;
            v2   <= '0;
        end else if (ram_we) begin
            case (addr)
                `PROT_ADDR_DATA: data <= merge_bytes(data, din, dsn);
                `PROT_ADDR_CMD:  cmd  <= merge_bytes(cmd, din, dsn);
                `PROT_ADDR_V0:   v0   <= merge_bytes(v0, din, dsn);
                `PROT_ADDR_V1:   v1   <= merge_bytes(v1, din, dsn);
                `PROT_ADDR_V2:   v2   <= merge_bytes(v2, din, dsn);
                default: ;
            endcase
        end
    end

    // position calc, all shifts logical on 16 bits
    always_comb begin
        x        = (v0 + 16'd32) >> 3;
        x_neg    = -x;
        hi       = {5'd0, x_neg[4:0], 6'd0};
        s        = v1 + v2 - 16'd6;
        // round toward zero fix for negative sums
        carry    = {15'd0, s[15] & (|s[2:0])};
        calc_nxt = hi + (((s >> 3) + carry + 16'd12) & 16'h003f);
    end

    // calc stage then answer stage
    always_ff @(posedge clk) begin
        calc <= calc_nxt;
        case (prot_cmd_e'(cmd))
            CMD_ID:                 dout <= 16'h0064;
            CMD_LOW4:               dout <= {12'd0, data[3:0]};
            CMD_LOW5:               dout <= {11'd0, data[4:0]};
            CMD_BIT0:               dout <= {15'd0, data[0]};
            CMD_BYTE_A, CMD_BYTE_B: dout <= {8'd0, data[7:0]};
            CMD_CALC:               dout <= calc;
            default:                dout <= 16'hffff;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/prot_pkg.sv ====
/* shared types: object RAM word views
   and protection command codes */
`include "prot_defs.svh"
`default_nettype none

package prot_pkg;

    // split view of an object attribute word
    typedef struct packed {
        logic [7:0] prio;   // logical priority, one-hot
        logic [7:0] attr;
    } obj_fields_t;

    // same 16 bits, raw or split
    typedef union packed {
        logic [15:0] raw;
        obj_fields_t fld;
    } obj_word_u;

    typedef enum logic [15:0] {
        CMD_ID     = `PROT_CMD_ID,
        CMD_LOW4   = `PROT_CMD_LOW4,
        CMD_LOW5   = `PROT_CMD_LOW5,
        CMD_BIT0   = `PROT_CMD_BIT0,
        CMD_BYTE_A = `PROT_CMD_BYTE_A,
        CMD_BYTE_B = `PROT_CMD_BYTE_B,
        CMD_CALC   = `PROT_CMD_CALC
    } prot_cmd_e;

endpackage

`default_nettype wire

// ==== hw/prot_top.sv ====
/* protection and object DMA subsystem top: step enable, mailbox,
   DMA engine and object RAM */
`timescale 1ns/10ps
`default_nettype none

module prot_top (
    input  wire         clk,
    input  wire         rst,
    // CPU side
    input  wire  [13:1] addr,
    input  wire  [ 1:0] dsn,
    input  wire  [15:0] din,
    input  wire         cpu_we,
    input  wire         prot_cs,
    input  wire         ram_we,
    input  wire         obj_cs,
    output logic [15:0] prot_dout,
    output logic [15:0] obj_rdata,
    // bus handshake
    output logic        bus_req,
    input  wire         bus_grant,
    output logic        bus_ack
);

    import prot_pkg::*;

    logic        cen_dma;
    // object RAM port, owned by the DMA block
    logic        oram_cs;
    logic [13:1] oram_addr;
    logic [15:0] oram_wdata;
    logic [ 1:0] oram_we;
    obj_word_u   oram_rdata;

    assign obj_rdata = oram_rdata.raw;

    cen_gen i_cen_gen (
        .clk     (clk),
        .rst     (rst),
        .cen_dma (cen_dma)
    );

    prot_mailbox i_prot_mailbox (
        .clk    (clk),
        .rst    (rst),
        .ram_we (ram_we),
        .addr   (addr),
        .dsn    (dsn),
        .din    (din),
        .dout   (prot_dout)
    );

    prio_dma i_prio_dma (
        .clk        (clk),
        .rst        (rst),
        .cen_dma    (cen_dma),
        .prot_cs    (prot_cs),
        .cpu_we     (cpu_we),
        .obj_cs     (obj_cs),
        .addr       (addr),
        .dsn        (dsn),
        .din        (din),
        .bus_req    (bus_req),
        .bus_grant  (bus_grant),
        .bus_ack    (bus_ack),
        .oram_cs    (oram_cs),
        .oram_addr  (oram_addr),
        .oram_wdata (oram_wdata),
        .oram_we    (oram_we),
        .oram_rdata (oram_rdata)
    );

    obj_ram i_obj_ram (
        .clk   (clk),
        .cs    (oram_cs),
        .addr  (oram_addr),
        .we    (oram_we),
        .wdata (oram_wdata),
        .rdata (oram_rdata)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
    -f vlog.f --top-module tb_prot -o tb_prot

out=$(./obj_dir/tb_prot)
echo "$out"
echo "$out" | grep -q "Simulation PASSED"

// ==== testbench/tb_ref_model.svh ====
/* expected values: position calculation, answer table,
   CPU address of an object pin address, sweep numbering */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// position formula on plain integers, 16-bit wrap done by modulo
function automatic logic [15:0] calc_position(input logic [15:0] v0,
                                              input logic [15:0] v1,
                                              input logic [15:0] v2);
    int x;
    int hi;
    int u;
    int carry;
    x     = ((int'(v0) + 32) % 65536) / 8;
    // low five bits of -x, moved up by six
    hi    = ((32 - (x % 32)) % 32) * 64;
    // wrapped sum, values from 32768 up are negative
    u     = (int'(v1) + int'(v2) + 65536 - 6) % 65536;
    carry = (u >= 32768 && (u % 8) != 0) ? 1 : 0;
    return 16'(hi + ((u / 8 + carry + 12) % 64));
endfunction

// answer table per command code
function automatic logic [15:0] expected_answer(input logic [15:0] cmd,
                                                input logic [15:0] data,
                                                input logic [15:0] calc);
    logic [15:0] ans;
    case (cmd)
        CMD_ID:     ans = 16'h0064;
        CMD_LOW4:   ans = data & 16'h000f;
        CMD_LOW5:   ans = data & 16'h001f;
        CMD_BIT0:   ans = data & 16'h0001;
        CMD_BYTE_A: ans = data & 16'h00ff;
        CMD_BYTE_B: ans = data & 16'h00ff;
        CMD_CALC:   ans = calc;
        default:    ans = 16'hffff;
    endcase
    return ans;
endfunction

// CPU address that lands on pin address p
function automatic logic [13:1] cpu_addr_of(input logic [13:1] p);
    return {p[10:4], p[13:12], p[3:1], p[11]};
endfunction

// number given to entry idx, 0 when it sits at no level
function automatic logic [7:0] sweep_number(input logic [7:0] tab [0:127],
                                            input int idx);
    int         rank;
    logic [7:0] num;
    rank = 1;
    num  = 8'd0;
    // levels low to high, entries in index order
    for (int lv = 0; lv < 8; lv++) begin
        for (int e = 0; e < 128; e++) begin
            if (tab[e] == (8'd1 << lv)) begin
                if (e == idx)
                    num = 8'(rank);
                rank = rank + 1;
            end
        end
    end
    return num;
endfunction

`endif

// ==== testbench/tb_prot.sv ====
/* testbench for the protection subsystem: mailbox answers,
   position calculation, object RAM scramble and priority sweep */
`timescale 1ns/10ps
`include "prot_defs.svh"
`default_nettype none

module tb_prot;

    import prot_pkg::*;

    `include "tb_ref_model.svh"

    // full sweep plus margin
    localparam int SWEEP_LIMIT = 8 * 128 * 4 * `PROT_CEN_DIV + 200;

    logic        clk;
    logic        rst;
    logic [13:1] addr;
    logic [ 1:0] dsn;
    logic [15:0] din;
    logic        cpu_we;
    logic        prot_cs;
    logic        ram_we;
    logic        obj_cs;
    logic        bus_grant;
    logic [15:0] prot_dout;
    logic [15:0] obj_rdata;
    logic        bus_req;
    logic        bus_ack;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          tests;
    int          test_base;
    // pending checks for the next rising edge
    string       q_name [$];
    logic [15:0] q_got [$];
    logic [15:0] q_exp [$];
    // mirror of the snooped registers
    logic [15:0] data_cur;
    logic [15:0] v0_cur;
    logic [15:0] v1_cur;
    logic [15:0] v2_cur;
    logic [ 7:0] prio_tab [0:127];
    logic [15:0] word_tab [0:127];
    logic [13:1] a_tab [0:15];
    logic [15:0] d_tab [0:15];

    prot_top i_prot_top (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .dsn       (dsn),
        .din       (din),
        .cpu_we    (cpu_we),
        .prot_cs   (prot_cs),
        .ram_we    (ram_we),
        .obj_cs    (obj_cs),
        .prot_dout (prot_dout),
        .obj_rdata (obj_rdata),
        .bus_req   (bus_req),
        .bus_grant (bus_grant),
        .bus_ack   (bus_ack)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // compare process
    always @(posedge clk) begin
        while (q_name.size() > 0) begin
            checks = checks + 1;
            if (q_got[0] !== q_exp[0]) begin
                $display("Mismatch %s: got 0x%04h, expected 0x%04h at %0t",
                         q_name[0], q_got[0], q_exp[0], $time);
                errors = errors + 1;
            end
            void'(q_name.pop_front());
            void'(q_got.pop_front());
            void'(q_exp.pop_front());
        end
    end

    task automatic queue_check(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        q_name.push_back(name);
        q_got.push_back(got);
        q_exp.push_back(exp);
    endtask

    task automatic drive_idle();
        addr    = '0;
        dsn     = 2'b11;
        din     = '0;
        cpu_we  = 1'b0;
        prot_cs = 1'b0;
        ram_we  = 1'b0;
        obj_cs  = 1'b0;
    endtask

    // shared RAM write picked up by the snoop
    task automatic shared_write(input logic [13:1] a, input logic [15:0] d,
                                input logic [1:0] strobe_n);
        @(negedge clk);
        addr   = a;
        din    = d;
        dsn    = strobe_n;
        cpu_we = 1'b1;
        ram_we = 1'b1;
        @(negedge clk);
        drive_idle();
    endtask

    task automatic obj_write(input logic [13:1] a, input logic [15:0] d);
        @(negedge clk);
        addr   = a;
        din    = d;
        dsn    = 2'b00;
        cpu_we = 1'b1;
        obj_cs = 1'b1;
        @(negedge clk);
        drive_idle();
    endtask

    // CPU write while watching the pin address at the RAM
    task automatic pin_addr_write(input logic [13:1] a, input logic [15:0] d,
                                  input logic [13:1] pin);
        @(negedge clk);
        addr   = a;
        din    = d;
        dsn    = 2'b00;
        cpu_we = 1'b1;
        obj_cs = 1'b1;
        @(negedge clk);
        queue_check("oram_addr", {3'd0, i_prot_top.oram_addr}, {3'd0, pin});
        drive_idle();
    endtask

    // registered read data is ready one edge later
    task automatic obj_read_check(input logic [13:1] a, input logic [15:0] exp);
        @(negedge clk);
        addr   = a;
        dsn    = 2'b00;
        obj_cs = 1'b1;
        @(negedge clk);
        drive_idle();
        queue_check("obj_rdata", obj_rdata, exp);
    endtask

    // covers the extra calc register stage
    task automatic mailbox_check(input logic [15:0] exp);
        repeat (2) @(negedge clk);
        queue_check("prot_dout", prot_dout, exp);
    endtask

    task automatic wait_signal(input string what, input logic is_ack,
                               input logic level, input int limit);
        int n;
        n = 0;
        while ((is_ack ? bus_ack : bus_req) !== level && n < limit) begin
            @(negedge clk);
            n = n + 1;
        end
        if ((is_ack ? bus_ack : bus_req) !== level) begin
            $display("timeout after %0d cycles waiting for %s", limit, what);
            errors = errors + 1;
        end
    endtask

    task automatic end_test(input string name);
        // lets the compare process drain
        @(negedge clk);
        tests = tests + 1;
        if (errors == test_base)
            $display("test %-12s ok", name);
        else
            $display("test %-12s fail, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        logic [15:0] code;
        logic [ 7:0] num;
        prot_cmd_e   c;
        obj_word_u   ent;
        int          i;
        clk       = 1'b0;
        rst       = 1'b1;
        bus_grant = 1'b0;
        drive_idle();
        rng       = 32'hac14;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_base = 0;
        data_cur  = '0;
        v0_cur    = '0;
        v1_cur    = '0;
        v2_cur    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset state answers command 0 with data 0
        @(negedge clk);
        queue_check("bus_req", {15'd0, bus_req}, 16'd0);
        queue_check("bus_ack", {15'd0, bus_ack}, 16'd0);
        queue_check("prot_dout", prot_dout, expected_answer(16'h0000, 16'h0000, 16'h0000));
        end_test("reset");

        rng = lcg(rng);
        data_cur = rng[31:16];
        shared_write(`PROT_ADDR_DATA, data_cur, 2'b00);
        c = c.first();
        for (i = 0; i < 8; i++) begin
            // last pass is a code outside the table
            code = (i == 7) ? 16'h1234 : 16'(c);
            shared_write(`PROT_ADDR_CMD, code, 2'b00);
            mailbox_check(expected_answer(code, data_cur,
                                          calc_position(v0_cur, v1_cur, v2_cur)));
            c = c.next();
        end
        end_test("cmd_table");

        shared_write(`PROT_ADDR_CMD, CMD_BYTE_A, 2'b00);
        rng = lcg(rng);
        // upper byte only so the low byte stays
        shared_write(`PROT_ADDR_DATA, rng[31:16], 2'b01);
        data_cur = {rng[31:24], data_cur[7:0]};
        mailbox_check(expected_answer(CMD_BYTE_A, data_cur, 16'h0000));
        rng = lcg(rng);
        shared_write(`PROT_ADDR_DATA, rng[31:16], 2'b10);
        data_cur = {data_cur[15:8], rng[23:16]};
        mailbox_check(expected_answer(CMD_BYTE_A, data_cur, 16'h0000));
        end_test("byte_strobe");

        shared_write(`PROT_ADDR_CMD, CMD_CALC, 2'b00);
        for (i = 0; i < 40; i++) begin
            rng = lcg(rng);
            v0_cur = rng[31:16];
            rng = lcg(rng);
            // odd passes push v1 negative
            v1_cur = rng[31:16] | {i[0], 15'd0};
            rng = lcg(rng);
            v2_cur = rng[31:16];
            shared_write(`PROT_ADDR_V0, v0_cur, 2'b00);
            shared_write(`PROT_ADDR_V1, v1_cur, 2'b00);
            shared_write(`PROT_ADDR_V2, v2_cur, 2'b00);
            mailbox_check(expected_answer(CMD_CALC, data_cur,
                                          calc_position(v0_cur, v1_cur, v2_cur)));
        end
        end_test("position");

        for (i = 0; i < 16; i++) begin
            rng = lcg(rng);
            // index in the top bits keeps addresses apart
            a_tab[i] = {i[5:0], rng[22:16]};
            rng = lcg(rng);
            d_tab[i] = rng[31:16];
            obj_write(a_tab[i], d_tab[i]);
        end
        for (i = 0; i < 16; i++)
            obj_read_check(a_tab[i], d_tab[i]);
        rng = lcg(rng);
        pin_addr_write(cpu_addr_of(13'h0a40), rng[31:16], 13'h0a40);
        obj_read_check(cpu_addr_of(13'h0a40), rng[31:16]);
        end_test("obj_scramble");

        // attribute words at CPU {entry, 3} and targets at pin entry*8
        for (i = 0; i < 128; i++) begin
            rng = lcg(rng);
            prio_tab[i] = rng[20] ? (8'd1 << rng[23:21]) : 8'd0;
            ent.fld.prio = prio_tab[i];
            ent.fld.attr = rng[31:24];
            obj_write({i[6:0], 6'd3}, ent.raw);
            rng = lcg(rng);
            word_tab[i] = rng[31:16];
            obj_write(cpu_addr_of({3'd0, i[6:0], 3'd0}), word_tab[i]);
        end
        @(negedge clk);
        addr    = {6'd0, `PROT_TRIG_OFS};
        cpu_we  = 1'b1;
        prot_cs = 1'b1;
        @(negedge clk);
        drive_idle();
        wait_signal("bus_req high", 1'b0, 1'b1, 10);
        // request must hold while grant is withheld
        repeat (5) @(negedge clk);
        queue_check("bus_req", {15'd0, bus_req}, 16'd1);
        bus_grant = 1'b1;
        wait_signal("bus_ack high", 1'b1, 1'b1, 10);
        queue_check("bus_req", {15'd0, bus_req}, 16'd0);
        wait_signal("bus_ack low", 1'b1, 1'b0, SWEEP_LIMIT);
        bus_grant = 1'b0;
        for (i = 0; i < 128; i++) begin
            num  = sweep_number(prio_tab, i);
            // only the low byte gets the number
            code = (num != 8'd0) ? {word_tab[i][15:8], num} : word_tab[i];
            obj_read_check(cpu_addr_of({3'd0, i[6:0], 3'd0}), code);
        end
        end_test("prio_sweep");

        @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
+incdir+testbench
hw/prot_pkg.sv
hw/cen_gen.sv
hw/prot_mailbox.sv
hw/prio_dma.sv
hw/obj_ram.sv
hw/prot_top.sv
testbench/tb_prot.sv
